// ==== logic/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    ////////////////////
    // Widths and sizes
    ////////////////////

    // Data path, PC and instruction width
    localparam int XLEN = 32;

    // Instruction RAM depth in words
    localparam int IMEM_WORDS = 256;
    localparam int IMEM_ADDR_W = 8;

    // First fetch address out of reset
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    ////////////////////
    // Encodings
    ////////////////////

    // Hazard unit code, a level from the back end
    // Only the two stall codes freeze the front end
    typedef enum logic [3:0] {
        haz_none        = 4'b0000,
        haz_stall_early = 4'b0001,
        haz_stall_mmu   = 4'b0010,
        haz_flush       = 4'b0100
    } hazard_t;

    // RV32I major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_op_imm = 7'b0010011,
        op_op     = 7'b0110011,
        op_system = 7'b1110011
    } opcode_t;

endpackage

`default_nettype wire

// ==== logic/fetch_slot_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// One fetched word in flight between RAM read and early decode
interface fetch_slot_if;

    // PC the word was read from
    logic [fetch_pkg::XLEN-1:0] slot_pc;
    // Raw instruction, zero when faulted
    logic [fetch_pkg::XLEN-1:0] slot_instr;
    // Slot carries a real fetch, not a bubble
    logic                       slot_valid;
    // PC was outside the instruction RAM
    logic                       slot_fault;

    // Memory stage side
    modport mem (
        output slot_pc,
        output slot_instr,
        output slot_valid,
        output slot_fault
    );

    // Decode stage side
    modport dec (
        input slot_pc,
        input slot_instr,
        input slot_valid,
        input slot_fault
    );

endinterface

`default_nettype wire

// ==== logic/pc_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module pc_gen (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [fetch_pkg::XLEN-1:0] alu_target,
    input  logic                       pc_select,
    input  logic                       mispredict,
    input  logic [fetch_pkg::XLEN-1:0] saved_pc,
    input  logic                       csr_redirect,
    input  logic [fetch_pkg::XLEN-1:0] csr_target,
    input  fetch_pkg::hazard_t         hazard,
    input  logic                       fence,
    input  logic                       jump_taken,
    input  logic [fetch_pkg::XLEN-1:0] jump_offset,
    output logic [fetch_pkg::XLEN-1:0] pc,
    output logic                       pc_valid,
    output logic                       hold,
    output logic                       flush_front,
    output logic                       flush_late
);

    // pc_live  : pc holds an address still to be fetched
    // pc_used  : pc already fetched, held by a fence
    logic                       pc_live;
    logic                       pc_used;
    logic                       live_next;
    logic                       used_next;
    logic                       stall;
    logic                       be_redirect;
    logic [fetch_pkg::XLEN-1:0] pc_next;
    logic [fetch_pkg::XLEN-1:0] jump_base;

    ////////////////////
    // Control decode
    ////////////////////

    assign stall = (hazard == fetch_pkg::haz_stall_early) ||
                   (hazard == fetch_pkg::haz_stall_mmu);
    assign be_redirect = csr_redirect | pc_select;

    // Back-end redirect outranks a stall
    assign hold = stall & ~be_redirect;
    assign flush_late = be_redirect;
    // Early jump only counts once the stall lifts
    assign flush_front = be_redirect | (jump_taken & ~stall);
    assign pc_valid = pc_live & ~hold;

    // Jump PC sits one word behind pc, unless a fence kept pc on it
    assign jump_base = pc_used ? pc : pc - 4;

    ////////////////////
    // Next PC
    ////////////////////

    always_comb begin
        pc_next = pc;
        live_next = pc_live;
        used_next = pc_used;
        if (csr_redirect) begin
            pc_next = csr_target;
            live_next = 1'b1;
            used_next = 1'b0;
        end else if (pc_select) begin
            // Mispredict returns to the fall-through path
            pc_next = mispredict ? saved_pc + 4 : alu_target;
            live_next = 1'b1;
            used_next = 1'b0;
        end else if (hold) begin
            // Freeze everything
            pc_next = pc;
        end else if (jump_taken) begin
            pc_next = jump_base + jump_offset;
            live_next = 1'b1;
            used_next = 1'b0;
        end else if (fence) begin
            // Last presented word still goes out, then bubbles
            live_next = 1'b0;
            used_next = pc_used | pc_live;
        end else if (pc_live | pc_used) begin
            pc_next = pc + 4;
            live_next = 1'b1;
            used_next = 1'b0;
        end else begin
            // First cycle out of reset, present RESET_PC
            live_next = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= fetch_pkg::RESET_PC;
            pc_live <= 1'b0;
            pc_used <= 1'b0;
        end else begin
            pc <= pc_next;
            pc_live <= live_next;
            pc_used <= used_next;
        end
    end

endmodule

`default_nettype wire

// ==== logic/imem_read.sv ====
`timescale 1ns/1ps
`default_nettype none

module imem_read (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              load_en,
    input  logic [fetch_pkg::IMEM_ADDR_W-1:0] load_addr,
    input  logic [fetch_pkg::XLEN-1:0]        load_data,
    input  logic [fetch_pkg::XLEN-1:0]        pc,
    input  logic                              pc_valid,
    input  logic                              hold,
    input  logic                              flush_front,
    fetch_slot_if.mem                         slot
);

    // Word storage, filled through the load port
    logic [fetch_pkg::XLEN-1:0] mem [0:fetch_pkg::IMEM_WORDS-1];

    logic [fetch_pkg::IMEM_ADDR_W-1:0] word_addr;
    logic                              in_range;

    ////////////////////
    // Address check
    ////////////////////

    // Byte PC to word index, low two bits dropped
    assign word_addr = pc[fetch_pkg::IMEM_ADDR_W+1:2];

    // Any bit above the RAM window marks a fault
    assign in_range = (pc[fetch_pkg::XLEN-1:fetch_pkg::IMEM_ADDR_W+2] == '0);

    ////////////////////
    // RAM
    ////////////////////

    // Load port
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    ////////////////////
    // Fetch slot
    ////////////////////

    // Control bits of the slot
    always_ff @(posedge clk) begin
        if (rst) begin
            slot.slot_valid <= 1'b0;
            slot.slot_fault <= 1'b0;
        end else if (flush_front) begin
            // Wrong-path word dropped
            slot.slot_valid <= 1'b0;
            slot.slot_fault <= 1'b0;
        end else if (!hold) begin
            slot.slot_valid <= pc_valid;
            slot.slot_fault <= pc_valid & ~in_range;
        end
    end

    // Payload, synchronous read
    always_ff @(posedge clk) begin
        if (!hold) begin
            slot.slot_pc <= pc;
            if (in_range) begin
                slot.slot_instr <= mem[word_addr];
            end else begin
                // Faulted fetch reads as zero
                slot.slot_instr <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/early_jump_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module early_jump_decode (
    input  logic                       clk,
    input  logic                       rst,
    fetch_slot_if.dec                  slot,
    input  logic                       hold,
    input  logic                       flush_late,
    output logic                       jump_taken,
    output logic [fetch_pkg::XLEN-1:0] jump_offset,
    output logic [fetch_pkg::XLEN-1:0] dec_pc,
    output logic [fetch_pkg::XLEN-1:0] dec_instr,
    output logic                       dec_valid,
    output logic                       dec_pred_taken,
    output logic                       dec_fault
);

    fetch_pkg::opcode_t         opcode;
    logic [fetch_pkg::XLEN-1:0] instr;
    logic [fetch_pkg::XLEN-1:0] imm_j;
    logic [fetch_pkg::XLEN-1:0] imm_b;
    logic                       is_jal;
    logic                       is_branch;
    logic                       predict;
    logic                       slot_live;

    assign instr = slot.slot_instr;
    assign opcode = fetch_pkg::opcode_t'(instr[6:0]);

    ////////////////////
    // Immediates
    ////////////////////

    // J-type, imm[20|10:1|11|19:12]
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};

    // B-type, imm[12|10:5] and imm[4:1|11]
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};

    ////////////////////
    // Classify
    ////////////////////

    always_comb begin
        is_jal = 1'b0;
        is_branch = 1'b0;
        case (opcode)
            fetch_pkg::op_jal: begin
                is_jal = 1'b1;
            end
            fetch_pkg::op_branch: begin
                is_branch = 1'b1;
            end
            // JALR and the rest resolve in execute
            default: begin
                is_jal = 1'b0;
            end
        endcase
    end

    // Static rule, JAL always, branch only backward
    assign predict = is_jal | (is_branch & imm_b[fetch_pkg::XLEN-1]);

    // Bubbles and faulted slots never redirect
    assign slot_live = slot.slot_valid & ~slot.slot_fault;

    assign jump_taken = slot_live & predict;
    assign jump_offset = is_jal ? imm_j : imm_b;

    ////////////////////
    // Output register
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
            dec_pred_taken <= 1'b0;
            dec_fault <= 1'b0;
        end else if (flush_late) begin
            // Back-end redirect kills the older path
            dec_valid <= 1'b0;
            dec_pred_taken <= 1'b0;
            dec_fault <= 1'b0;
        end else if (!hold) begin
            dec_valid <= slot.slot_valid;
            dec_pred_taken <= slot_live & predict;
            dec_fault <= slot.slot_valid & slot.slot_fault;
        end
    end

    // Slot payload toward the back end
    always_ff @(posedge clk) begin
        if (!hold) begin
            dec_pc <= slot.slot_pc;
            dec_instr <= slot.slot_instr;
        end
    end

endmodule

`default_nettype wire

// ==== logic/fetch_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend (
    input  logic                              clk,
    input  logic                              rst,
    // Back-end redirects
    input  logic [fetch_pkg::XLEN-1:0]        alu_target,
    input  logic                              pc_select,
    input  logic                              mispredict,
    input  logic [fetch_pkg::XLEN-1:0]        saved_pc,
    input  logic                              csr_redirect,
    input  logic [fetch_pkg::XLEN-1:0]        csr_target,
    // Holds
    input  fetch_pkg::hazard_t                hazard,
    input  logic                              fence,
    // Instruction RAM load
    input  logic                              imem_load_en,
    input  logic [fetch_pkg::IMEM_ADDR_W-1:0] imem_load_addr,
    input  logic [fetch_pkg::XLEN-1:0]        imem_load_data,
    // Decoded slot out
    output logic [fetch_pkg::XLEN-1:0]        dec_pc,
    output logic [fetch_pkg::XLEN-1:0]        dec_instr,
    output logic                              dec_valid,
    output logic                              dec_pred_taken,
    output logic                              dec_fault
);

    // PC stage outputs
    logic [fetch_pkg::XLEN-1:0] pc;
    logic                       pc_valid;
    logic                       hold;
    logic                       flush_front;
    logic                       flush_late;

    // Early jump feedback
    logic                       jump_taken;
    logic [fetch_pkg::XLEN-1:0] jump_offset;

    // Memory to decode
    fetch_slot_if slot_bus ();

    ////////////////////
    // Stages
    ////////////////////

    pc_gen u_pc_gen (
        .clk          (clk),
        .rst          (rst),
        .alu_target   (alu_target),
        .pc_select    (pc_select),
        .mispredict   (mispredict),
        .saved_pc     (saved_pc),
        .csr_redirect (csr_redirect),
        .csr_target   (csr_target),
        .hazard       (hazard),
        .fence        (fence),
        .jump_taken   (jump_taken),
        .jump_offset  (jump_offset),
        .pc           (pc),
        .pc_valid     (pc_valid),
        .hold         (hold),
        .flush_front  (flush_front),
        .flush_late   (flush_late)
    );

    imem_read u_imem_read (
        .clk         (clk),
        .rst         (rst),
        .load_en     (imem_load_en),
        .load_addr   (imem_load_addr),
        .load_data   (imem_load_data),
        .pc          (pc),
        .pc_valid    (pc_valid),
        .hold        (hold),
        .flush_front (flush_front),
        .slot        (slot_bus.mem)
    );

    early_jump_decode u_early_jump_decode (
        .clk            (clk),
        .rst            (rst),
        .slot           (slot_bus.dec),
        .hold           (hold),
        .flush_late     (flush_late),
        .jump_taken     (jump_taken),
        .jump_offset    (jump_offset),
        .dec_pc         (dec_pc),
        .dec_instr      (dec_instr),
        .dec_valid      (dec_valid),
        .dec_pred_taken (dec_pred_taken),
        .dec_fault      (dec_fault)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_fetch_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_frontend;

    logic                              clk;
    logic                              rst;
    logic [fetch_pkg::XLEN-1:0]        alu_target;
    logic                              pc_select;
    logic                              mispredict;
    logic [fetch_pkg::XLEN-1:0]        saved_pc;
    logic                              csr_redirect;
    logic [fetch_pkg::XLEN-1:0]        csr_target;
    fetch_pkg::hazard_t                hazard;
    logic                              fence;
    logic                              imem_load_en;
    logic [fetch_pkg::IMEM_ADDR_W-1:0] imem_load_addr;
    logic [fetch_pkg::XLEN-1:0]        imem_load_data;
    logic [fetch_pkg::XLEN-1:0]        dec_pc;
    logic [fetch_pkg::XLEN-1:0]        dec_instr;
    logic                              dec_valid;
    logic                              dec_pred_taken;
    logic                              dec_fault;

    // Program image plus per-word jump info for the model
    logic [fetch_pkg::XLEN-1:0] prog [0:fetch_pkg::IMEM_WORDS-1];
    logic                       taken_tab [0:fetch_pkg::IMEM_WORDS-1];
    logic [fetch_pkg::XLEN-1:0] off_tab [0:fetch_pkg::IMEM_WORDS-1];

    // Head of the expected decode stream
    logic [fetch_pkg::XLEN-1:0] exp_pc;
    logic [fetch_pkg::XLEN-1:0] exp_instr;
    logic [fetch_pkg::XLEN-1:0] exp_off;
    logic                       exp_pred;
    logic                       exp_fault;

    // Stall and fence tracking
    logic                       stall_now;
    logic                       held;
    logic [fetch_pkg::XLEN-1:0] snap_pc;
    logic                       snap_valid;
    int                         fence_run;

    int                         mismatch_count;
    int                         fail_count;
    logic                       timed_out;

    fetch_frontend dut0 (
        .clk            (clk),
        .rst            (rst),
        .alu_target     (alu_target),
        .pc_select      (pc_select),
        .mispredict     (mispredict),
        .saved_pc       (saved_pc),
        .csr_redirect   (csr_redirect),
        .csr_target     (csr_target),
        .hazard         (hazard),
        .fence          (fence),
        .imem_load_en   (imem_load_en),
        .imem_load_addr (imem_load_addr),
        .imem_load_data (imem_load_data),
        .dec_pc         (dec_pc),
        .dec_instr      (dec_instr),
        .dec_valid      (dec_valid),
        .dec_pred_taken (dec_pred_taken),
        .dec_fault      (dec_fault)
    );

    // 100 ns clock
    initial clk = 1'b0;
    always #50 clk = ~clk;

    ////////////////////
    // Program helpers
    ////////////////////

    // JAL x0 with a byte offset, always predicted taken
    function automatic void place_jal(input int word, input int off);
        prog[word] = {off[20], off[10:1], off[11], off[19:12], 5'd0, fetch_pkg::op_jal};
        taken_tab[word] = 1'b1;
        off_tab[word] = off;
    endfunction

    // Conditional branch on x1, x2; taken only when backward
    function automatic void place_branch(input int word, input int off, input logic [2:0] f3);
        prog[word] = {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11],
                      fetch_pkg::op_branch};
        taken_tab[word] = (off < 0);
        off_tab[word] = off;
    endfunction

    function automatic void build_program();
        for (int i = 0; i < fetch_pkg::IMEM_WORDS; i++) begin
            // addi x1, x0, word index
            prog[i] = {4'h0, i[7:0], 5'd0, 3'b000, 5'd1, fetch_pkg::op_op_imm};
            taken_tab[i] = 1'b0;
            off_tab[i] = '0;
        end
        // Loop 0x00..0x58 with a JAL, a forward and a backward branch
        place_jal(8, 32);
        place_branch(20, 16, 3'b000);
        place_branch(22, -88, 3'b001);
        // Far JAL out of the RAM window, to 0x800
        place_jal(64, 32'h700);
    endfunction

    function automatic logic in_imem(input logic [fetch_pkg::XLEN-1:0] a);
        return a < fetch_pkg::IMEM_WORDS * 4;
    endfunction

    function automatic logic [fetch_pkg::XLEN-1:0] expected_word(
        input logic [fetch_pkg::XLEN-1:0] a);
        return in_imem(a) ? prog[a[fetch_pkg::IMEM_ADDR_W+1:2]] : '0;
    endfunction

    function automatic logic expected_taken(input logic [fetch_pkg::XLEN-1:0] a);
        return in_imem(a) ? taken_tab[a[fetch_pkg::IMEM_ADDR_W+1:2]] : 1'b0;
    endfunction

    function automatic logic [fetch_pkg::XLEN-1:0] expected_offset(
        input logic [fetch_pkg::XLEN-1:0] a);
        return in_imem(a) ? off_tab[a[fetch_pkg::IMEM_ADDR_W+1:2]] : '0;
    endfunction

    // Word aligned target inside the loop region
    function automatic logic [fetch_pkg::XLEN-1:0] random_pc();
        return $urandom_range(0, 23) * 4;
    endfunction

    ////////////////////
    // Reference model
    ////////////////////

    // Stall codes freeze the front end unless a redirect comes too
    assign stall_now = ((hazard == fetch_pkg::haz_stall_early) ||
                        (hazard == fetch_pkg::haz_stall_mmu)) &&
                       !pc_select && !csr_redirect;

    // Advance on each edge where the DUT hands a slot on
    always @(posedge clk) begin : model_step
        logic [fetch_pkg::XLEN-1:0] next_pc;
        next_pc = exp_pc;
        if (rst) begin
            next_pc = fetch_pkg::RESET_PC;
        end else if (csr_redirect) begin
            next_pc = csr_target;
        end else if (pc_select) begin
            next_pc = mispredict ? saved_pc + 4 : alu_target;
        end else if (dec_valid && !stall_now) begin
            next_pc = exp_pred ? exp_pc + exp_off : exp_pc + 4;
        end
        exp_pc <= next_pc;
        exp_instr <= expected_word(next_pc);
        exp_pred <= expected_taken(next_pc);
        exp_off <= expected_offset(next_pc);
        exp_fault <= !in_imem(next_pc);
        // Outputs seen before a stalled edge must survive it
        held <= !rst && stall_now;
        snap_pc <= dec_pc;
        snap_valid <= dec_valid;
        if (rst || !fence) begin
            fence_run <= 0;
        end else begin
            fence_run <= fence_run + 1;
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        mismatch_count++;
        $display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, exp_val, act_val);
    endtask

    task automatic report_failure(input string why);
        fail_count++;
        $display("FAILURE at %0t ns: %s", $time, why);
    endtask

    // Sampled mid-cycle, away from both edge activity and input changes
    check_pc: assert property (@(negedge clk) disable iff (rst)
        !dec_valid || dec_pc == exp_pc)
        else report_mismatch("dec_pc", exp_pc, dec_pc);
    check_instr: assert property (@(negedge clk) disable iff (rst)
        !dec_valid || dec_instr == exp_instr)
        else report_mismatch("dec_instr", exp_instr, dec_instr);
    check_pred: assert property (@(negedge clk) disable iff (rst)
        !dec_valid || dec_pred_taken == exp_pred)
        else report_mismatch("dec_pred_taken", 32'(exp_pred), 32'(dec_pred_taken));
    check_fault: assert property (@(negedge clk) disable iff (rst)
        !dec_valid || dec_fault == exp_fault)
        else report_mismatch("dec_fault", 32'(exp_fault), 32'(dec_fault));
    check_held_pc: assert property (@(negedge clk) disable iff (rst)
        !held || dec_pc == snap_pc)
        else report_mismatch("dec_pc (stalled)", snap_pc, dec_pc);
    check_held_valid: assert property (@(negedge clk) disable iff (rst)
        !held || dec_valid == snap_valid)
        else report_mismatch("dec_valid (stalled)", 32'(snap_valid), 32'(dec_valid));
    // Five fence edges cover even a jump caught in the slot
    check_fence_drain: assert property (@(negedge clk) disable iff (rst)
        fence_run < 5 || !dec_valid)
        else report_failure("valid decode slot still present after the fence drained");

    ////////////////////
    // Stimulus
    ////////////////////

    // Inputs move 1 ns past the rising edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic load_program();
        for (int i = 0; i < fetch_pkg::IMEM_WORDS; i++) begin
            step();
            imem_load_en = 1'b1;
            imem_load_addr = i[fetch_pkg::IMEM_ADDR_W-1:0];
            imem_load_data = prog[i];
        end
        step();
        imem_load_en = 1'b0;
    endtask

    task automatic wait_slots(input int n);
        int seen;
        int cycles;
        seen = 0;
        cycles = 0;
        while (!timed_out && seen < n) begin
            @(negedge clk);
            cycles++;
            if (dec_valid) begin
                seen++;
            end
            if (seen < n && cycles >= 200) begin
                timed_out = 1'b1;
                report_failure($sformatf("only %0d of %0d decode slots arrived", seen, n));
            end
        end
    endtask

    task automatic wait_fault();
        int cycles;
        logic seen;
        cycles = 0;
        seen = 1'b0;
        while (!timed_out && !seen) begin
            @(negedge clk);
            cycles++;
            seen = dec_valid && dec_fault;
            if (!seen && cycles >= 200) begin
                timed_out = 1'b1;
                report_failure("no faulted decode slot after the far jump");
            end
        end
    endtask

    task automatic stall_window(input int len);
        step();
        if ($urandom_range(0, 1) == 0) begin
            hazard = fetch_pkg::haz_stall_early;
        end else begin
            hazard = fetch_pkg::haz_stall_mmu;
        end
        repeat (len) step();
        hazard = fetch_pkg::haz_none;
    endtask

    // One-cycle back-end strobe
    task automatic strobe_redirect(input logic [31:0] alu, input logic [31:0] saved,
                                   input logic [31:0] trap, input logic use_csr,
                                   input logic use_misp);
        step();
        alu_target = alu;
        saved_pc = saved;
        csr_target = trap;
        pc_select = 1'b1;
        mispredict = use_misp;
        csr_redirect = use_csr;
        step();
        pc_select = 1'b0;
        mispredict = 1'b0;
        csr_redirect = 1'b0;
        wait_slots(6);
    endtask

    initial begin
        void'($urandom(32'hba4210f1));
        mismatch_count = 0;
        fail_count = 0;
        timed_out = 1'b0;
        rst = 1'b1;
        alu_target = '0;
        pc_select = 1'b0;
        mispredict = 1'b0;
        saved_pc = '0;
        csr_redirect = 1'b0;
        csr_target = '0;
        hazard = fetch_pkg::haz_none;
        fence = 1'b0;
        imem_load_en = 1'b0;
        imem_load_addr = '0;
        imem_load_data = '0;

        // Program goes in under reset, then 8 more reset cycles
        build_program();
        load_program();
        repeat (8) step();
        rst = 1'b0;

        // Free run twice round the loop, haz_flush in the second pass
        wait_slots(12);
        step();
        hazard = fetch_pkg::haz_flush;
        wait_slots(30);
        step();
        hazard = fetch_pkg::haz_none;

        // Random stall windows at random points in the loop
        repeat (8) begin
            stall_window($urandom_range(1, 5));
            wait_slots($urandom_range(1, 6));
        end

        repeat (2) begin
            step();
            fence = 1'b1;
            repeat (8) step();
            fence = 1'b0;
            wait_slots($urandom_range(4, 12));
        end

        // ALU target, mispredict fall-through, CSR over PC select
        repeat (3) begin
            strobe_redirect(random_pc(), random_pc(), random_pc(), 1'b0, 1'b0);
            strobe_redirect(random_pc(), random_pc(), random_pc(), 1'b0, 1'b1);
            strobe_redirect(random_pc(), random_pc(), random_pc(), 1'b1, 1'b0);
        end

        // Far JAL at 0x100, then back to the loop
        strobe_redirect(32'h100, '0, '0, 1'b0, 1'b0);
        wait_fault();
        strobe_redirect(fetch_pkg::RESET_PC, '0, '0, 1'b0, 1'b0);
        wait_slots(10);

        step();
        $display("Summary: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== fetch_frontend.f ====
logic/fetch_pkg.sv
logic/fetch_slot_if.sv
logic/pc_gen.sv
logic/imem_read.sv
logic/early_jump_decode.sv
logic/fetch_frontend.sv
testbench/tb_fetch_frontend.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the fetch front end testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module tb_fetch_frontend \
    -f fetch_frontend.f

./obj_dir/Vtb_fetch_frontend | tee sim.log

if grep -q "All tests passed!" sim.log; then
    echo "Simulation result: PASS"
else
    echo "Simulation result: FAIL"
    exit 1
fi
